// ==== hdl/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path and address width.
`define CPU_XLEN 32

// Architectural register file.
`define CPU_REG_COUNT 32
`define CPU_REG_AW 5

// Address of the first instruction fetched after reset.
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // One instruction word, seen as R-type fields or as the U-type layout.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [19:0] imm_hi;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } inst_u;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        INST_TYPE_NONE    = 3'd0,
        INST_TYPE_IMM     = 3'd1,
        INST_TYPE_INT_IMM = 3'd2,
        INST_TYPE_INT_REG = 3'd3,
        INST_TYPE_BRANCH  = 3'd4
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_OR     = 4'd4,
        ALU_AND    = 4'd5,
        ALU_PASS_B = 4'd6,
        ALU_EQ     = 4'd7,
        ALU_NE     = 4'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        FETCH_S = 2'd0,
        LOAD_S  = 2'd1,
        EXEC_S  = 2'd2,
        WB_S    = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_fetch_start,
    input  logic [`CPU_XLEN-1:0] i_pc,
    input  logic                 i_ir_addr_ready,
    input  logic                 i_ir_data_valid,
    input  logic [`CPU_XLEN-1:0] i_ir_data,
    output logic                 o_ir_addr_valid,
    output logic [`CPU_XLEN-1:0] o_ir_addr,
    output logic                 o_ir_data_ready,
    output logic                 o_fetch_done,
    output logic [`CPU_XLEN-1:0] o_inst
);

    logic                 addr_pend;
    logic                 data_pend;
    logic                 data_xfer;
    logic [`CPU_XLEN-1:0] req_addr;
    logic [`CPU_XLEN-1:0] inst_q;

    assign data_xfer = data_pend && i_ir_data_valid;

    // Only one request in flight, so a start while busy is ignored.
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_pend <= 1'b0;
            data_pend <= 1'b0;
        end else begin
            if (i_fetch_start && !addr_pend && !data_pend) begin
                addr_pend <= 1'b1;
            end
            if (addr_pend && i_ir_addr_ready) begin
                addr_pend <= 1'b0;
                data_pend <= 1'b1; // Ready rises only after the address is taken.
            end
            if (data_xfer) begin
                data_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetch_start && !addr_pend && !data_pend) begin
            req_addr <= i_pc;
        end
        if (data_xfer) begin
            inst_q <= i_ir_data;
        end
    end

    assign o_ir_addr_valid = addr_pend;
    assign o_ir_addr       = req_addr;
    assign o_ir_data_ready = data_pend;
    assign o_fetch_done    = data_xfer;
    // The word is forwarded in the transfer cycle so the decoder can take it at once.
    assign o_inst          = data_xfer ? i_ir_data : inst_q;

endmodule

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module inst_decoder import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_inst_valid,
    input  inst_u                  i_inst,
    output logic [`CPU_REG_AW-1:0] o_rs1,
    output logic [`CPU_REG_AW-1:0] o_rs2,
    output logic [`CPU_REG_AW-1:0] o_rd,
    output logic [`CPU_XLEN-1:0]   o_imm,
    output inst_type_e             o_inst_type,
    output alu_op_e                o_alu_op,
    output logic                   o_use_imm,
    output logic                   o_writes_rd
);

    inst_type_e           dec_type;
    alu_op_e              dec_op;
    logic                 dec_use_imm;
    logic                 dec_writes;
    logic [`CPU_XLEN-1:0] imm_i;
    logic [`CPU_XLEN-1:0] imm_b;
    logic [`CPU_XLEN-1:0] imm_u;

    assign imm_i = {{20{i_inst.r.funct7[6]}}, i_inst.r.funct7, i_inst.r.rs2};
    assign imm_b = {{19{i_inst.r.funct7[6]}}, i_inst.r.funct7[6], i_inst.r.rd[0],
                    i_inst.r.funct7[5:0], i_inst.r.rd[4:1], 1'b0};
    assign imm_u = {i_inst.u.imm_hi, 12'b0};

    always_comb begin
        dec_type    = INST_TYPE_NONE;
        dec_op      = ALU_ADD;
        dec_use_imm = 1'b0;
        dec_writes  = 1'b0;
        case (opcode_e'(i_inst.r.opcode))
            OP_LUI: begin
                dec_type    = INST_TYPE_IMM;
                dec_op      = ALU_PASS_B;
                dec_use_imm = 1'b1;
                dec_writes  = 1'b1;
            end
            OP_IMM: begin
                dec_use_imm = 1'b1;
                dec_writes  = 1'b1;
                dec_type    = INST_TYPE_INT_IMM;
                case (i_inst.r.funct3)
                    3'b000: dec_op = ALU_ADD;
                    3'b010: dec_op = ALU_SLT;
                    3'b100: dec_op = ALU_XOR;
                    3'b110: dec_op = ALU_OR;
                    3'b111: dec_op = ALU_AND;
                    default: begin
                        dec_type    = INST_TYPE_NONE; // Shifts and SLTIU are not supported.
                        dec_use_imm = 1'b0;
                        dec_writes  = 1'b0;
                    end
                endcase
            end
            OP_REG: begin
                dec_type   = INST_TYPE_INT_REG;
                dec_writes = 1'b1;
                case ({i_inst.r.funct7, i_inst.r.funct3})
                    10'b0000000_000: dec_op = ALU_ADD;
                    10'b0100000_000: dec_op = ALU_SUB;
                    10'b0000000_010: dec_op = ALU_SLT;
                    10'b0000000_100: dec_op = ALU_XOR;
                    10'b0000000_110: dec_op = ALU_OR;
                    10'b0000000_111: dec_op = ALU_AND;
                    default: begin
                        dec_type   = INST_TYPE_NONE;
                        dec_writes = 1'b0;
                    end
                endcase
            end
            OP_BRANCH: begin
                dec_type = INST_TYPE_BRANCH;
                case (i_inst.r.funct3)
                    3'b000:  dec_op = ALU_EQ;
                    3'b001:  dec_op = ALU_NE;
                    default: dec_type = INST_TYPE_NONE;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_inst_type <= INST_TYPE_NONE;
            o_alu_op    <= ALU_ADD;
            o_use_imm   <= 1'b0;
            o_writes_rd <= 1'b0;
        end else if (i_inst_valid) begin
            o_inst_type <= dec_type;
            o_alu_op    <= dec_op;
            o_use_imm   <= dec_use_imm;
            o_writes_rd <= dec_writes;
        end
    end

    always_ff @(posedge clk) begin
        if (i_inst_valid) begin
            o_rs1 <= i_inst.r.rs1;
            o_rs2 <= i_inst.r.rs2;
            o_rd  <= i_inst.u.rd;
            if (opcode_e'(i_inst.u.opcode) == OP_LUI) begin
                o_imm <= imm_u;
            end else if (opcode_e'(i_inst.r.opcode) == OP_BRANCH) begin
                o_imm <= imm_b;
            end else begin
                o_imm <= imm_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_rs1_en,
    input  logic [`CPU_REG_AW-1:0] i_rs1,
    input  logic                   i_rs2_en,
    input  logic [`CPU_REG_AW-1:0] i_rs2,
    input  logic                   i_rd_en,
    input  logic [`CPU_REG_AW-1:0] i_rd,
    input  logic [`CPU_XLEN-1:0]   i_rd_din,
    output logic [`CPU_XLEN-1:0]   o_rs1_dout,
    output logic [`CPU_XLEN-1:0]   o_rs2_dout
);

    logic [`CPU_XLEN-1:0] regs [0:`CPU_REG_COUNT-1];

    // Entry zero is cleared by reset and never written, so x0 reads zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_en && (i_rd != '0)) begin
            regs[i_rd] <= i_rd_din;
        end
    end

    // An idle read port returns zero on the next cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            o_rs1_dout <= '0;
            o_rs2_dout <= '0;
        end else begin
            o_rs1_dout <= i_rs1_en ? regs[i_rs1] : '0;
            o_rs2_dout <= i_rs2_en ? regs[i_rs2] : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module alu import cpu_pkg::*; (
    input  alu_op_e              i_op,
    input  logic [`CPU_XLEN-1:0] i_a,
    input  logic [`CPU_XLEN-1:0] i_b,
    output logic [`CPU_XLEN-1:0] o_result,
    output logic                 o_cond
);

    logic slt;

    assign slt = $signed(i_a) < $signed(i_b);

    always_comb begin
        o_result = '0;
        o_cond   = 1'b0;
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_SLT:    o_result = {{(`CPU_XLEN-1){1'b0}}, slt};
            ALU_XOR:    o_result = i_a ^ i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_PASS_B: o_result = i_b; // LUI carries its value in the immediate.
            ALU_EQ:     o_cond   = (i_a == i_b);
            ALU_NE:     o_cond   = (i_a != i_b);
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module control_fsm import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_fetch_done,
    input  logic [`CPU_REG_AW-1:0] i_rs1_from_dec,
    input  logic [`CPU_REG_AW-1:0] i_rs2_from_dec,
    input  inst_type_e             i_inst_type,
    input  logic                   i_use_imm,
    input  logic                   i_writes_rd,
    input  logic [`CPU_REG_AW-1:0] i_rd,
    input  logic [`CPU_XLEN-1:0]   i_imm,
    input  logic [`CPU_XLEN-1:0]   i_rs2_dout,
    input  logic [`CPU_XLEN-1:0]   i_alu_result,
    input  logic                   i_alu_cond,
    output logic                   o_fetch_start,
    output logic [`CPU_XLEN-1:0]   o_pc,
    output logic                   o_rs1_en,
    output logic                   o_rs2_en,
    output logic [`CPU_XLEN-1:0]   o_alu_b,
    output logic                   o_rd_en,
    output logic [`CPU_XLEN-1:0]   o_rd_din
);

    ctrl_state_e          state;
    ctrl_state_e          state_next;
    logic                 dec_ready;
    logic                 read_issue;
    logic                 reads_rs1;
    logic                 reads_rs2;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] result_q;
    logic                 cond_q;

    always_comb begin
        case (state)
            FETCH_S: state_next = LOAD_S;
            LOAD_S:  state_next = dec_ready ? EXEC_S : LOAD_S;
            EXEC_S:  state_next = WB_S;
            WB_S:    state_next = FETCH_S;
            default: state_next = FETCH_S;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= FETCH_S;
            dec_ready <= 1'b0;
            pc        <= `CPU_RESET_PC;
        end else begin
            state     <= state_next;
            dec_ready <= (state == LOAD_S) && i_fetch_done; // Decoder output is valid next cycle.
            if (state == WB_S) begin
                if ((i_inst_type == INST_TYPE_BRANCH) && cond_q) begin
                    pc <= pc + i_imm;
                end else begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    // The result is held through WB so the read ports are free to go idle.
    always_ff @(posedge clk) begin
        if (state == EXEC_S) begin
            result_q <= i_alu_result;
            cond_q   <= i_alu_cond;
        end
    end

    assign read_issue = (state == LOAD_S) && dec_ready;
    assign reads_rs1  = (i_inst_type == INST_TYPE_INT_IMM) ||
                        (i_inst_type == INST_TYPE_INT_REG) ||
                        (i_inst_type == INST_TYPE_BRANCH);
    assign reads_rs2  = !i_use_imm && (i_inst_type != INST_TYPE_NONE);

    // x0 needs no array access since an idle port returns zero.
    assign o_rs1_en = read_issue && reads_rs1 && (i_rs1_from_dec != '0);
    assign o_rs2_en = read_issue && reads_rs2 && (i_rs2_from_dec != '0);

    assign o_fetch_start = (state == FETCH_S);
    assign o_pc          = pc;
    assign o_alu_b       = i_use_imm ? i_imm : i_rs2_dout;
    assign o_rd_en       = (state == WB_S) && i_writes_rd && (i_rd != '0);
    assign o_rd_din      = result_q;

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_core import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   i_ir_addr_ready,
    input  logic                   i_ir_data_valid,
    input  logic [`CPU_XLEN-1:0]   i_ir_data,
    output logic                   o_ir_addr_valid,
    output logic [`CPU_XLEN-1:0]   o_ir_addr,
    output logic                   o_ir_data_ready,
    output logic                   o_wb_valid,
    output logic [`CPU_REG_AW-1:0] o_wb_rd,
    output logic [`CPU_XLEN-1:0]   o_wb_data
);

    logic                   fetch_start;
    logic                   fetch_done;
    logic [`CPU_XLEN-1:0]   pc;
    logic [`CPU_XLEN-1:0]   inst;
    logic [`CPU_REG_AW-1:0] rs1;
    logic [`CPU_REG_AW-1:0] rs2;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_XLEN-1:0]   imm;
    inst_type_e             inst_type;
    alu_op_e                alu_op;
    logic                   use_imm;
    logic                   writes_rd;
    logic                   rs1_en;
    logic                   rs2_en;
    logic [`CPU_XLEN-1:0]   rs1_dout;
    logic [`CPU_XLEN-1:0]   rs2_dout;
    logic [`CPU_XLEN-1:0]   alu_b;
    logic [`CPU_XLEN-1:0]   alu_result;
    logic                   alu_cond;
    logic                   rd_en;
    logic [`CPU_XLEN-1:0]   rd_din;

    control_fsm control (
        .clk            (clk),
        .rst            (rst),
        .i_fetch_done   (fetch_done),
        .i_rs1_from_dec (rs1),
        .i_rs2_from_dec (rs2),
        .i_inst_type    (inst_type),
        .i_use_imm      (use_imm),
        .i_writes_rd    (writes_rd),
        .i_rd           (rd),
        .i_imm          (imm),
        .i_rs2_dout     (rs2_dout),
        .i_alu_result   (alu_result),
        .i_alu_cond     (alu_cond),
        .o_fetch_start  (fetch_start),
        .o_pc           (pc),
        .o_rs1_en       (rs1_en),
        .o_rs2_en       (rs2_en),
        .o_alu_b        (alu_b),
        .o_rd_en        (rd_en),
        .o_rd_din       (rd_din)
    );

    fetch_unit fetch (
        .clk             (clk),
        .rst             (rst),
        .i_fetch_start   (fetch_start),
        .i_pc            (pc),
        .i_ir_addr_ready (i_ir_addr_ready),
        .i_ir_data_valid (i_ir_data_valid),
        .i_ir_data       (i_ir_data),
        .o_ir_addr_valid (o_ir_addr_valid),
        .o_ir_addr       (o_ir_addr),
        .o_ir_data_ready (o_ir_data_ready),
        .o_fetch_done    (fetch_done),
        .o_inst          (inst)
    );

    inst_decoder idec (
        .clk          (clk),
        .rst          (rst),
        .i_inst_valid (fetch_done),
        .i_inst       (inst),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_rd         (rd),
        .o_imm        (imm),
        .o_inst_type  (inst_type),
        .o_alu_op     (alu_op),
        .o_use_imm    (use_imm),
        .o_writes_rd  (writes_rd)
    );

    reg_file regfile (
        .clk        (clk),
        .rst        (rst),
        .i_rs1_en   (rs1_en),
        .i_rs1      (rs1),
        .i_rs2_en   (rs2_en),
        .i_rs2      (rs2),
        .i_rd_en    (rd_en),
        .i_rd       (rd),
        .i_rd_din   (rd_din),
        .o_rs1_dout (rs1_dout),
        .o_rs2_dout (rs2_dout)
    );

    alu alu0 (
        .i_op     (alu_op),
        .i_a      (rs1_dout),
        .i_b      (alu_b),
        .o_result (alu_result),
        .o_cond   (alu_cond)
    );

    // The register file write port doubles as the writeback trace.
    assign o_wb_valid = rd_en;
    assign o_wb_rd    = rd;
    assign o_wb_data  = rd_din;

endmodule

`default_nettype wire

// ==== verification/cpu_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_monitor import cpu_pkg::*; #(
    parameter int FETCH_BASE = 'h40,
    parameter int WB_BASE    = 'h80
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [31:0]            i_stim [0:255],
    input  logic                   o_ir_addr_valid,
    input  logic [`CPU_XLEN-1:0]   o_ir_addr,
    input  logic                   i_ir_addr_ready,
    input  logic                   i_ir_data_valid,
    input  logic [`CPU_XLEN-1:0]   i_ir_data,
    input  logic                   o_ir_data_ready,
    input  logic                   o_wb_valid,
    input  logic [`CPU_REG_AW-1:0] o_wb_rd,
    input  logic [`CPU_XLEN-1:0]   o_wb_data,
    output logic                   o_done,
    output int                     o_errors,
    output int                     o_timeouts
);

    int         fetch_idx = 0;
    int         wb_idx    = 0;
    int         idle      = 0;
    inst_type_e rx_class;

    initial begin
        o_done     = 1'b0;
        o_errors   = 0;
        o_timeouts = 0;
    end

    function automatic logic [31:0] stim_at(input int i);
        return i_stim[8'(i)];
    endfunction

    // Classifies a received word by its major opcode for the trace.
    function automatic inst_type_e word_class(input logic [31:0] w);
        case (w[6:0])
            OP_LUI:    return INST_TYPE_IMM;
            OP_IMM:    return INST_TYPE_INT_IMM;
            OP_REG:    return INST_TYPE_INT_REG;
            OP_BRANCH: return INST_TYPE_BRANCH;
            default:   return INST_TYPE_NONE;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %08h got %08h", name, exp, act);
            o_errors++;
        end
    endtask

    // Sampled at the falling edge, where valid and ready show the next edge's transfers.
    always @(negedge clk) begin
        if (rst) begin
            if (o_ir_addr_valid !== 1'b0 || o_ir_data_ready !== 1'b0 || o_wb_valid !== 1'b0) begin
                $display("Core drove a valid or ready output high during reset.");
                o_errors++;
            end
        end else if (!o_done) begin
            idle++;
            if (o_ir_addr_valid && i_ir_addr_ready) begin
                idle = 0;
                $display("[%0t] FETCH addr=%08h", $time, o_ir_addr);
                if (fetch_idx == 0) begin
                    compare("o_ir_addr", `CPU_RESET_PC, o_ir_addr);
                end
                if (fetch_idx < int'(stim_at(FETCH_BASE))) begin
                    compare("o_ir_addr", stim_at(FETCH_BASE + 1 + fetch_idx), o_ir_addr);
                end
                fetch_idx++;
            end
            if (i_ir_data_valid && o_ir_data_ready) begin
                rx_class = word_class(i_ir_data);
                $display("[%0t] INST  word=%08h type=%s", $time, i_ir_data, rx_class.name());
            end
            if (o_wb_valid) begin
                idle = 0;
                $display("[%0t] WB    x%0d <= %08h", $time, o_wb_rd, o_wb_data);
                if (wb_idx < int'(stim_at(WB_BASE))) begin
                    compare("o_wb_rd", stim_at(WB_BASE + 1 + 2 * wb_idx), {27'b0, o_wb_rd});
                    compare("o_wb_data", stim_at(WB_BASE + 2 + 2 * wb_idx), o_wb_data);
                end else begin
                    $display("Writeback seen after the expected list was used up.");
                    o_errors++;
                end
                wb_idx++;
            end
            if (fetch_idx >= int'(stim_at(FETCH_BASE)) && wb_idx >= int'(stim_at(WB_BASE))) begin
                o_done = 1'b1;
            end else if (idle >= 200) begin
                $display("No fetch or writeback activity for 200 cycles.");
                o_timeouts++;
                o_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu_core;

    localparam int PROG_BASE  = 'h00;
    localparam int FETCH_BASE = 'h40;
    localparam int WB_BASE    = 'h80;
    localparam int WAIT_LIMIT = 200;
    localparam int RUN_LIMIT  = 20000;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   i_ir_addr_ready;
    logic                   i_ir_data_valid;
    logic [`CPU_XLEN-1:0]   i_ir_data;
    logic                   o_ir_addr_valid;
    logic [`CPU_XLEN-1:0]   o_ir_addr;
    logic                   o_ir_data_ready;
    logic                   o_wb_valid;
    logic [`CPU_REG_AW-1:0] o_wb_rd;
    logic [`CPU_XLEN-1:0]   o_wb_data;

    logic [31:0] stim [0:255];
    logic [31:0] rng_state = 32'h5aed;
    logic        mon_done;
    int          mon_errors;
    int          mon_timeouts;
    int          mem_timeouts = 0;

    always #10 clk = ~clk;

    cpu_core u_dut (
        .clk             (clk),
        .rst             (rst),
        .i_ir_addr_ready (i_ir_addr_ready),
        .i_ir_data_valid (i_ir_data_valid),
        .i_ir_data       (i_ir_data),
        .o_ir_addr_valid (o_ir_addr_valid),
        .o_ir_addr       (o_ir_addr),
        .o_ir_data_ready (o_ir_data_ready),
        .o_wb_valid      (o_wb_valid),
        .o_wb_rd         (o_wb_rd),
        .o_wb_data       (o_wb_data)
    );

    cpu_monitor #(
        .FETCH_BASE (FETCH_BASE),
        .WB_BASE    (WB_BASE)
    ) u_monitor (
        .clk             (clk),
        .rst             (rst),
        .i_stim          (stim),
        .o_ir_addr_valid (o_ir_addr_valid),
        .o_ir_addr       (o_ir_addr),
        .i_ir_addr_ready (i_ir_addr_ready),
        .i_ir_data_valid (i_ir_data_valid),
        .i_ir_data       (i_ir_data),
        .o_ir_data_ready (o_ir_data_ready),
        .o_wb_valid      (o_wb_valid),
        .o_wb_rd         (o_wb_rd),
        .o_wb_data       (o_wb_data),
        .o_done          (mon_done),
        .o_errors        (mon_errors),
        .o_timeouts      (mon_timeouts)
    );

    // Xorshift32 step; the low two bits give a bus delay of 0 to 3 cycles.
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic next_delay(output int cycles);
        rng_state = xorshift32(rng_state);
        cycles = int'(rng_state[1:0]);
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] program_word(input logic [31:0] addr);
        int n_prog;
        n_prog = int'(stim[8'(PROG_BASE)]);
        if ((addr >> 2) < 32'(n_prog)) begin
            return stim[8'(PROG_BASE + 1) + 8'(addr >> 2)];
        end
        return 32'h0000_0000; // Opcode zero decodes as a no-op.
    endfunction

    // Serves one fetch, stalling the address channel and then the data channel.
    task automatic serve_fetch(output logic ok);
        int          n;
        int          delay;
        logic [31:0] addr;
        ok = 1'b0;
        n = 0;
        while (!o_ir_addr_valid && n < WAIT_LIMIT) begin
            step_cycle();
            n++;
        end
        if (!o_ir_addr_valid) begin
            $display("Memory model saw no address request within %0d cycles.", WAIT_LIMIT);
            return;
        end
        addr = o_ir_addr;
        next_delay(delay);
        repeat (delay) step_cycle();
        i_ir_addr_ready = 1'b1;
        step_cycle();
        i_ir_addr_ready = 1'b0;
        next_delay(delay);
        repeat (delay) step_cycle();
        i_ir_data_valid = 1'b1;
        i_ir_data       = program_word(addr);
        n = 0;
        while (!o_ir_data_ready && n < WAIT_LIMIT) begin
            step_cycle();
            n++;
        end
        if (!o_ir_data_ready) begin
            $display("Core never became ready for instruction data within %0d cycles.",
                     WAIT_LIMIT);
            return;
        end
        step_cycle();
        i_ir_data_valid = 1'b0;
        ok = 1'b1;
    endtask

    initial begin
        logic ok;
        int   n;
        n = 0;
        while (rst !== 1'b0 && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        #1;
        ok = 1'b1;
        while (ok) begin
            serve_fetch(ok);
        end
        mem_timeouts++;
    end

    initial begin
        int n;
        int run_timeouts;
        rst             = 1'b1;
        i_ir_addr_ready = 1'b0;
        i_ir_data_valid = 1'b0;
        i_ir_data       = '0;
        run_timeouts    = 0;
        for (int i = 0; i < 256; i++) begin
            stim[i] = '0;
        end
        $readmemh("verification/program_stim.txt", stim);
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        n = 0;
        while (!mon_done && n < RUN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!mon_done) begin
            $display("Run did not complete within %0d cycles.", RUN_LIMIT);
            run_timeouts++;
        end
        $display("Summary: %0d errors, %0d timeouts", mon_errors,
                 mon_timeouts + mem_timeouts + run_timeouts);
        if (mon_errors == 0 && mon_timeouts == 0 && mem_timeouts == 0 && run_timeouts == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/program_stim.txt ====
// Section @000: program word count, then instruction words from address 0.
// Section @040: fetch address count, then addresses. Section @080: count, then rd and data pairs.
@000
00000017
00500093 FFD00113 00112193 FFF0C213
0F00E293 03C2F313 002083B3 40208433
001124B3 00524533 003365B3 00557633
123456B7 00708013 00100733 00208463
00209463 00100793 00918463 00200793
00171463 FFF70793 00000063
@040
00000016
00000000 00000004 00000008 0000000C 00000010 00000014
00000018 0000001C 00000020 00000024 00000028 0000002C
00000030 00000034 00000038 0000003C 00000040 00000048
00000050 00000054 00000058 00000058
@080
0000000F
00000001 00000005 00000002 FFFFFFFD 00000003 00000001
00000004 FFFFFFFA 00000005 000000F5 00000006 00000034
00000007 00000002 00000008 00000008 00000009 00000001
0000000A FFFFFF0F 0000000B 00000035 0000000C 00000005
0000000D 12345000 0000000E 00000005 0000000F 00000004

// ==== cpu_core.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_unit.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/control_fsm.sv
hdl/cpu_core.sv
verification/cpu_monitor.sv
verification/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f cpu_core.f --top-module tb_cpu_core -o sim_cpu_core

output="$(./obj_dir/sim_cpu_core)"
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi
